// ==== design/byte_serializer.sv ====
`default_nettype none

module byte_serializer #(
	parameter int byte_width = 8,
	parameter bit lsb_first  = 1'b1
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  frame_start,
	input  logic [byte_width-1:0] byte_data,
	input  logic                  byte_valid,
	output logic                  byte_ready,
	output logic                  bit_out,
	output logic                  bit_valid,
	input  logic                  bit_ready
);
	import ofdm_tx_pkg::*;

	localparam int cnt_w = $clog2(byte_width + 1);

	logic [byte_width-1:0] shreg;
	// bits of the current byte still to leave
	logic [cnt_w-1:0]      bits_left;

	assign bit_valid  = (bits_left != '0);
	assign bit_out    = lsb_first ? shreg[0] : shreg[byte_width-1];
	assign byte_ready = (bits_left == '0) || (bits_left == cnt_w'(1) && bit_ready);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bits_left <= '0;
		else if (frame_start)
			bits_left <= '0;
		else if (byte_valid && byte_ready)
			bits_left <= cnt_w'(byte_width);
		else if (bit_valid && bit_ready)
			bits_left <= bits_left - cnt_w'(1);
	end

	// shift toward the output end
	always_ff @(posedge clk)
	begin
		if (byte_valid && byte_ready)
			shreg <= byte_data;
		else if (bit_valid && bit_ready)
			shreg <= lsb_first ? (shreg >> 1) : (shreg << 1);
	end

endmodule

`default_nettype wire

// ==== design/conv_encoder.sv ====
`default_nettype none

module conv_encoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     frame_start,
	input  logic                     bit_in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output ofdm_tx_pkg::coded_pair_t pair_out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import ofdm_tx_pkg::*;

	// tap masks over {history, current}, bit 0 is the current input
	// 133 octal taps delays 0,2,3,5,6 and 171 octal taps 0,1,2,3,6
	localparam logic [6:0] taps_a = 7'b1101101;
	localparam logic [6:0] taps_b = 7'b1001111;

	// hist[0] is the previous input bit
	logic [5:0]  hist;
	logic [6:0]  window;
	coded_pair_t next_pair;

	assign window      = {hist, bit_in};
	assign next_pair.a = ^(window & taps_a);
	assign next_pair.b = ^(window & taps_b);
	assign in_ready    = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hist      <= '0;
			out_valid <= 1'b0;
		end
		else if (frame_start)
		begin
			hist      <= '0;
			out_valid <= 1'b0;
		end
		else if (in_valid && in_ready)
		begin
			hist      <= {hist[4:0], bit_in};
			out_valid <= 1'b1;
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			pair_out <= next_pair;
	end

endmodule

`default_nettype wire

// ==== design/ofdm_tx_bits.sv ====
`default_nettype none

module ofdm_tx_bits #(
	parameter int byte_width = 8,
	parameter bit lsb_first  = 1'b1
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  ofdm_tx_pkg::rate_code_t  rate,
	input  logic                     frame_start,
	input  ofdm_tx_pkg::scram_seed_t seed,
	input  logic [byte_width-1:0]    byte_data,
	input  logic                     byte_valid,
	output logic                     byte_ready,
	output ofdm_tx_pkg::iq_sample_t  sample,
	output logic                     sample_valid,
	input  logic                     sample_ready
);
	import ofdm_tx_pkg::*;

	rate_info_t  info;

	logic        ser_bit;
	logic        ser_valid;
	logic        ser_ready;
	logic        scr_bit;
	logic        scr_valid;
	logic        scr_ready;
	coded_pair_t enc_pair;
	logic        enc_valid;
	logic        enc_ready;
	logic        pun_bit;
	logic        pun_valid;
	logic        pun_ready;

	// rate is held for the frame, so decode is purely combinational
	assign info = rate_decode(rate);

	// ------------------------------------------------------------
	// bit chain
	// ------------------------------------------------------------
	byte_serializer #(
		.byte_width (byte_width),
		.lsb_first  (lsb_first)
	) u_serializer (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.byte_data   (byte_data),
		.byte_valid  (byte_valid),
		.byte_ready  (byte_ready),
		.bit_out     (ser_bit),
		.bit_valid   (ser_valid),
		.bit_ready   (ser_ready)
	);

	scrambler u_scrambler (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.seed        (seed),
		.bit_in      (ser_bit),
		.in_valid    (ser_valid),
		.in_ready    (ser_ready),
		.bit_out     (scr_bit),
		.out_valid   (scr_valid),
		.out_ready   (scr_ready)
	);

	conv_encoder u_encoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.bit_in      (scr_bit),
		.in_valid    (scr_valid),
		.in_ready    (scr_ready),
		.pair_out    (enc_pair),
		.out_valid   (enc_valid),
		.out_ready   (enc_ready)
	);

	puncturer u_puncturer (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.code_rate   (info.code_rate),
		.pair_in     (enc_pair),
		.in_valid    (enc_valid),
		.in_ready    (enc_ready),
		.bit_out     (pun_bit),
		.out_valid   (pun_valid),
		.out_ready   (pun_ready)
	);

	// constellation samples out
	qam_mapper u_mapper (
		.clk          (clk),
		.rst_n        (rst_n),
		.frame_start  (frame_start),
		.modulation   (info.modulation),
		.bit_in       (pun_bit),
		.in_valid     (pun_valid),
		.in_ready     (pun_ready),
		.sample       (sample),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready)
	);

endmodule

`default_nettype wire

// ==== design/ofdm_tx_pkg.sv ====
`default_nettype none

package ofdm_tx_pkg;

	// ------------------------------------------------------------
	// rate field and its decoded form
	// ------------------------------------------------------------
	typedef logic [3:0] rate_code_t;

	localparam rate_code_t rate_6m  = 4'b1101;
	localparam rate_code_t rate_9m  = 4'b1111;
	localparam rate_code_t rate_12m = 4'b0101;
	localparam rate_code_t rate_18m = 4'b0111;
	localparam rate_code_t rate_24m = 4'b1001;
	localparam rate_code_t rate_36m = 4'b1011;

	typedef enum logic {rate_1_2, rate_3_4} code_rate_t;

	typedef enum logic [1:0] {mod_bpsk, mod_qpsk, mod_16qam} modulation_t;

	typedef struct packed {
		code_rate_t  code_rate;
		modulation_t modulation;
	} rate_info_t;

	// ------------------------------------------------------------
	// data path words
	// ------------------------------------------------------------
	// a from generator 133 and b from generator 171
	typedef struct packed {
		logic a;
		logic b;
	} coded_pair_t;

	typedef struct packed {
		logic signed [7:0] im;
		logic signed [7:0] re;
	} iq_sample_t;

	typedef logic [6:0] scram_seed_t;

	// constellation step of the inner ring
	localparam int map_unit = 16;

	function automatic rate_info_t rate_decode(input rate_code_t rate);
		rate_info_t info;
		case (rate)
			rate_9m:  info = '{code_rate: rate_3_4, modulation: mod_bpsk};
			rate_12m: info = '{code_rate: rate_1_2, modulation: mod_qpsk};
			rate_18m: info = '{code_rate: rate_3_4, modulation: mod_qpsk};
			rate_24m: info = '{code_rate: rate_1_2, modulation: mod_16qam};
			rate_36m: info = '{code_rate: rate_3_4, modulation: mod_16qam};
			// rate_6m and anything unknown
			default:  info = '{code_rate: rate_1_2, modulation: mod_bpsk};
		endcase
		return info;
	endfunction

endpackage

`default_nettype wire

// ==== design/puncturer.sv ====
`default_nettype none

module puncturer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     frame_start,
	input  ofdm_tx_pkg::code_rate_t  code_rate,
	input  ofdm_tx_pkg::coded_pair_t pair_in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output logic                     bit_out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import ofdm_tx_pkg::*;

	// position inside the 3-pair pattern of rate 3/4
	logic [1:0] phase;
	logic       pend_valid;
	logic       pend_bit;
	logic       take;
	logic       keep_both;

	assign in_ready  = !pend_valid && (!out_valid || out_ready);
	assign take      = in_valid && in_ready;
	assign keep_both = (code_rate == rate_1_2) || (phase == 2'd0);

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase      <= 2'd0;
			pend_valid <= 1'b0;
			out_valid  <= 1'b0;
		end
		else if (frame_start)
		begin
			phase      <= 2'd0;
			pend_valid <= 1'b0;
			out_valid  <= 1'b0;
		end
		else if (take)
		begin
			if (code_rate == rate_3_4)
				phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
			pend_valid <= keep_both;
			out_valid  <= 1'b1;
		end
		else if (pend_valid && out_ready)
			pend_valid <= 1'b0;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// ------------------------------------------------------------
	// data, pair 2 keeps a and pair 3 keeps b
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			bit_out  <= (keep_both || phase == 2'd1) ? pair_in.a : pair_in.b;
			pend_bit <= pair_in.b;
		end
		else if (pend_valid && out_ready)
			bit_out <= pend_bit;
	end

endmodule

`default_nettype wire

// ==== design/qam_mapper.sv ====
`default_nettype none

module qam_mapper (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     frame_start,
	input  ofdm_tx_pkg::modulation_t modulation,
	input  logic                     bit_in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output ofdm_tx_pkg::iq_sample_t  sample,
	output logic                     sample_valid,
	input  logic                     sample_ready
);
	import ofdm_tx_pkg::*;

	logic [3:0] bits;
	logic [1:0] cnt;
	logic [1:0] last_idx;
	logic [3:0] sym;
	logic       take;
	iq_sample_t next_sample;

	// one axis level, s picks the sign and inner the small ring
	function automatic logic signed [7:0] pam(input logic s, input logic inner);
		logic signed [7:0] mag;
		mag = inner ? 8'(map_unit) : 8'(3 * map_unit);
		return s ? mag : -mag;
	endfunction

	assign in_ready = !sample_valid || sample_ready;
	assign take     = in_valid && in_ready;

	always_comb
	begin
		case (modulation)
			mod_qpsk:  last_idx = 2'd1;
			mod_16qam: last_idx = 2'd3;
			default:   last_idx = 2'd0;
		endcase
	end

	// symbol bits b0..b3 with the arriving bit in place
	always_comb
	begin
		sym      = bits;
		sym[cnt] = bit_in;
	end

	// 16-QAM gray: 00 -3, 01 -1, 11 +1, 10 +3
	always_comb
	begin
		case (modulation)
			mod_qpsk:
			begin
				next_sample.re = pam(sym[0], 1'b1);
				next_sample.im = pam(sym[1], 1'b1);
			end
			mod_16qam:
			begin
				next_sample.re = pam(sym[0], sym[1]);
				next_sample.im = pam(sym[2], sym[3]);
			end
			default:
			begin
				next_sample.re = pam(sym[0], 1'b1);
				next_sample.im = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt          <= 2'd0;
			sample_valid <= 1'b0;
		end
		else if (frame_start)
		begin
			cnt          <= 2'd0;
			sample_valid <= 1'b0;
		end
		else if (take && cnt == last_idx)
		begin
			cnt          <= 2'd0;
			sample_valid <= 1'b1;
		end
		else
		begin
			if (take)
				cnt <= cnt + 2'd1;
			if (sample_valid && sample_ready)
				sample_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			bits <= sym;
		if (take && cnt == last_idx)
			sample <= next_sample;
	end

endmodule

`default_nettype wire

// ==== design/scrambler.sv ====
`default_nettype none

module scrambler (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     frame_start,
	input  ofdm_tx_pkg::scram_seed_t seed,
	input  logic                     bit_in,
	input  logic                     in_valid,
	output logic                     in_ready,
	output logic                     bit_out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import ofdm_tx_pkg::*;

	scram_seed_t state;
	logic        fb;

	// x^7 + x^4 + 1
	assign fb       = state[6] ^ state[3];
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= '1;
			out_valid <= 1'b0;
		end
		else if (frame_start)
		begin
			state     <= seed;
			out_valid <= 1'b0;
		end
		else if (in_valid && in_ready)
		begin
			// advance only when a bit is taken
			state     <= {state[5:0], fb};
			out_valid <= 1'b1;
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			bit_out <= bit_in ^ fb;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_ofdm_tx_bits -f sim.f -o tb_ofdm_tx_bits
./obj_dir/tb_ofdm_tx_bits | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== sim.f ====
+incdir+test
design/ofdm_tx_pkg.sv
design/byte_serializer.sv
design/scrambler.sv
design/conv_encoder.sv
design/puncturer.sv
design/qam_mapper.sv
design/ofdm_tx_bits.sv
test/tb_ofdm_tx_bits.sv

// ==== test/tx_ref_model.svh ====
`ifndef TX_REF_MODEL_SVH
`define TX_REF_MODEL_SVH

// ------------------------------------------------------------
// reference transmit chain, one bit at a time
// ------------------------------------------------------------

// 9, 18 and 36 Mbit/s are punctured to 3/4
function automatic bit punctured(input logic [3:0] rate);
	return rate == 4'b1111 || rate == 4'b0111 || rate == 4'b1011;
endfunction

// coded bits per constellation point
function automatic int point_bits(input logic [3:0] rate);
	case (rate)
		4'b0101, 4'b0111: return 2;
		4'b1001, 4'b1011: return 4;
		default:          return 1;
	endcase
endfunction

// bpsk and qpsk axis
function automatic logic signed [7:0] binary_level(input logic b);
	return b ? 8'sd16 : -8'sd16;
endfunction

// 16-qam axis, first bit then second
function automatic logic signed [7:0] gray_level(input logic first, input logic second);
	case ({first, second})
		2'b00:   return -8'sd48;
		2'b01:   return -8'sd16;
		2'b11:   return 8'sd16;
		default: return 8'sd48;
	endcase
endfunction

// expands frame_bytes into exp_q, each entry {im, re}
function automatic void build_expected(input logic [6:0] frame_seed, input logic [3:0] rate);
	logic [6:0] lfsr;
	logic [6:0] hist;
	logic [7:0] cur;
	logic       fb;
	logic       a;
	logic       b;
	logic       p0;
	logic       p1;
	logic       p2;
	logic       p3;
	logic       coded[$];
	int         phase;
	int         k;
	lfsr  = frame_seed;
	hist  = '0;
	phase = 0;
	foreach (frame_bytes[i])
	begin
		cur = frame_bytes[i];
		for (k = 0; k < 8; k++)
		begin
			fb   = lfsr[6] ^ lfsr[3];
			// hist[0] is the newest scrambled bit, hist[j] the one j bits earlier
			hist = {hist[5:0], cur[0] ^ fb};
			lfsr = {lfsr[5:0], fb};
			cur  = cur >> 1;
			a    = hist[0] ^ hist[2] ^ hist[3] ^ hist[5] ^ hist[6];
			b    = hist[0] ^ hist[1] ^ hist[2] ^ hist[3] ^ hist[6];
			if (!punctured(rate) || phase == 0)
			begin
				coded.push_back(a);
				coded.push_back(b);
			end
			else if (phase == 1)
				coded.push_back(a);
			else
				coded.push_back(b);
			if (punctured(rate))
				phase = (phase + 1) % 3;
		end
	end
	// b0 is the first coded bit of each point
	while (coded.size() >= point_bits(rate))
	begin
		p0 = coded.pop_front();
		if (point_bits(rate) == 1)
			exp_q.push_back({8'h00, binary_level(p0)});
		else if (point_bits(rate) == 2)
		begin
			p1 = coded.pop_front();
			exp_q.push_back({binary_level(p1), binary_level(p0)});
		end
		else
		begin
			p1 = coded.pop_front();
			p2 = coded.pop_front();
			p3 = coded.pop_front();
			exp_q.push_back({gray_level(p2, p3), gray_level(p0, p1)});
		end
	end
endfunction

`endif

// ==== test/tb_ofdm_tx_bits.sv ====
`default_nettype none

module tb_ofdm_tx_bits;

	localparam int          frame_len       = 12;
	localparam int          total_bytes     = 10 * frame_len;
	localparam int          watchdog_cycles = total_bytes * 8 * 4 * 3 + 2000;
	localparam int          frame_limit     = frame_len * 8 * 4 * 3;
	localparam logic [31:0] rng_seed        = 32'h1d64_f290;

	logic        clk;
	logic        rst_n;
	logic [3:0]  rate;
	logic        frame_start;
	logic [6:0]  seed;
	logic [7:0]  byte_data;
	logic        byte_valid;
	logic        byte_ready;
	logic [15:0] sample;
	logic        sample_valid;
	logic        sample_ready;

	logic [7:0]  frame_bytes[$];
	logic [15:0] exp_q[$];
	logic [15:0] exp_word;
	logic [31:0] rng_state;
	logic [6:0]  last_seed;
	logic        stall_on;
	int          got_count     = 0;
	int          bytes_taken   = 0;
	int          sample_errors = 0;
	int          check_errors;
	int          tests_run;
	int          tests_failed;

	`include "tx_ref_model.svh"

	ofdm_tx_bits #(
		.byte_width (8),
		.lsb_first  (1'b1)
	) UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.rate         (rate),
		.frame_start  (frame_start),
		.seed         (seed),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.byte_ready   (byte_ready),
		.sample       (sample),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// ------------------------------------------------------------
	// monitors on the rising edge
	// ------------------------------------------------------------
	always @(posedge clk)
	begin
		if (rst_n && byte_valid && byte_ready)
			bytes_taken = bytes_taken + 1;
	end

	always @(posedge clk)
	begin
		if (rst_n && sample_valid && sample_ready)
		begin
			got_count = got_count + 1;
			if (exp_q.size() == 0)
			begin
				$display("[FAIL] %0t an extra sample %h arrived with none expected", $time, sample);
				sample_errors = sample_errors + 1;
			end
			else
			begin
				exp_word = exp_q.pop_front();
				if (sample !== exp_word)
				begin
					$display("[FAIL] %0t sample expected %h got %h", $time, exp_word, sample);
					sample_errors = sample_errors + 1;
				end
			end
		end
	end

	// random output stalls, only while stall_on
	initial
	begin
		logic [31:0] stall_rng;
		stall_rng    = ~rng_seed;
		sample_ready = 1'b1;
		forever
		begin
			@(negedge clk);
			stall_rng    = xorshift(stall_rng);
			sample_ready = !(stall_on && stall_rng[0]);
		end
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("[FAIL] watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic check_reset_state();
		int n;
		int fails_before;
		fails_before = check_errors;
		tests_run    = tests_run + 1;
		for (n = 0; n < 8; n++)
		begin
			@(negedge clk);
			if (sample_valid !== 1'b0)
			begin
				$display("[FAIL] %0t sample_valid expected 0 got %b", $time, sample_valid);
				check_errors = check_errors + 1;
			end
			if (byte_ready !== 1'b1)
			begin
				$display("[FAIL] %0t byte_ready expected 1 got %b", $time, byte_ready);
				check_errors = check_errors + 1;
			end
		end
		if (check_errors == fails_before)
			$display("reset state: ok");
		else
		begin
			tests_failed = tests_failed + 1;
			$display("reset state: failed");
		end
	endtask

	// fixed_count below zero means no fixed sample count
	task automatic run_frame(input string name, input logic [3:0] frame_rate,
		input logic [6:0] frame_seed, input bit gaps, input int fixed_count);
		logic [31:0] r;
		int          i;
		int          fails_before;
		int          got_base;
		int          taken_base;
		int          n_exp;
		int          n_got;
		int          waited;
		fails_before = check_errors + sample_errors;
		tests_run    = tests_run + 1;
		exp_q.delete();
		build_expected(frame_seed, frame_rate);
		n_exp       = exp_q.size();
		got_base    = got_count;
		taken_base  = bytes_taken;
		rate        = frame_rate;
		seed        = frame_seed;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		for (i = 0; i < frame_len; i++)
		begin
			byte_data  = frame_bytes[i];
			byte_valid = 1'b1;
			while (bytes_taken <= taken_base + i)
				@(negedge clk);
			byte_valid = 1'b0;
			if (gaps)
			begin
				r = rand32();
				repeat (r[2:0]) @(negedge clk);
			end
		end
		waited = 0;
		while (got_count - got_base < n_exp && waited < frame_limit)
		begin
			@(negedge clk);
			waited = waited + 1;
		end
		// idle so that stray extra samples show up
		repeat (4) @(negedge clk);
		n_got = got_count - got_base;
		if (n_got != n_exp)
		begin
			$display("[FAIL] %0t %s: %0d of %0d samples arrived", $time, name, n_got, n_exp);
			check_errors = check_errors + 1;
		end
		if (fixed_count >= 0 && n_got != fixed_count)
		begin
			$display("[FAIL] %0t sample count expected %0d got %0d", $time, fixed_count, n_got);
			check_errors = check_errors + 1;
		end
		exp_q.delete();
		if (check_errors + sample_errors == fails_before)
			$display("%s: %0d samples ok", name, n_got);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("%s: failed", name);
		end
	endtask

	// new random bytes and a fresh nonzero seed
	task automatic random_frame(input string name, input logic [3:0] frame_rate);
		logic [31:0] r;
		logic [6:0]  s;
		frame_bytes.delete();
		repeat (frame_len)
		begin
			r = rand32();
			frame_bytes.push_back(r[7:0]);
		end
		s = last_seed;
		while (s == 7'h00 || s == last_seed)
		begin
			r = rand32();
			s = r[6:0];
		end
		last_seed = s;
		run_frame(name, frame_rate, s, 1'b0, -1);
	endtask

	initial
	begin
		rst_n        = 1'b0;
		rate         = 4'b1101;
		frame_start  = 1'b0;
		seed         = 7'h00;
		byte_data    = 8'h00;
		byte_valid   = 1'b0;
		stall_on     = 1'b0;
		last_seed    = 7'h00;
		rng_state    = rng_seed;
		check_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		check_reset_state();

		random_frame("rate 6", 4'b1101);
		random_frame("rate 9", 4'b1111);
		random_frame("rate 12", 4'b0101);
		random_frame("rate 18", 4'b0111);
		random_frame("rate 24", 4'b1001);
		random_frame("rate 36", 4'b1011);

		// same bytes and seed as the rate 36 frame
		stall_on = 1'b1;
		run_frame("rate 36 back-pressure", 4'b1011, last_seed, 1'b1, -1);
		stall_on = 1'b0;

		frame_bytes.delete();
		repeat (frame_len) frame_bytes.push_back(8'h00);
		run_frame("all-zero bytes at 6", 4'b1101, 7'b1011101, 1'b0, 192);

		random_frame("restart 18 first", 4'b0111);
		random_frame("restart 18 second", 4'b0111);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			check_errors + sample_errors);
		if (check_errors + sample_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
